/* flist.f */
rtl/vfu_pkg.sv
rtl/vfu_decoder.sv
rtl/vfu_sequencer.sv
rtl/vfu_ipu.sv
rtl/vfu_vrf.sv
rtl/vfu_top.sv
verif/tb_clock.sv
verif/tb_vfu.sv

/* run.sh */
#!/bin/sh
# Builds the vector unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  --top-module tb_vfu -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_vfu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

/* verif/tb_vfu.sv */
// Testbench for vfu_top with default parameters, N_IPU 2 and VELE 4
// A shadow copy of the register file predicts every readback word
// Concurrent assertions check readback data, illegal_o and group timing
`timescale 1ns/10ps
`default_nettype none

module tb_vfu;

  localparam int VELE     = 4;
  localparam int NR_WORDS = vfu_pkg::NR_VREG * VELE;
  // Roughly twice the cycles that the test list needs
  localparam int TIMEOUT_CYCLES = 20000;

  logic           clk_i;
  logic           rst_ni;
  logic           req_valid_i;
  logic           req_ready_o;
  logic [31:0]    insn_i;
  logic [31:0]    rs1_i;
  logic [7:0]     vl_i;
  vfu_pkg::vsew_e sew_i;
  logic           busy_o;
  logic           illegal_o;
  logic           host_we_i;
  logic [6:0]     host_addr_i;
  logic [63:0]    host_wdata_i;
  logic [7:0]     host_wbe_i;
  logic [6:0]     host_raddr_i;
  logic [63:0]    host_rdata_o;

  logic [63:0] model_mem [NR_WORDS];
  logic [63:0] rb_exp;
  logic        rb_check;
  string       test_name;
  int          req_len, cur_len, since_acc;
  int          cycle_cnt = 0;
  logic        req_illegal, cur_illegal;

  logic [5:0] op_codes [9] = '{vfu_pkg::F6_VADD, vfu_pkg::F6_VSUB, vfu_pkg::F6_VMIN,
                               vfu_pkg::F6_VMAX, vfu_pkg::F6_VAND, vfu_pkg::F6_VOR,
                               vfu_pkg::F6_VXOR, vfu_pkg::F6_VMUL, vfu_pkg::F6_VMACC};
  string      op_names [9] = '{"vadd", "vsub", "vmin", "vmax", "vand", "vor", "vxor",
                               "vmul", "vmacc"};

  tb_clock i_clock (.clk_o(clk_i));

  vfu_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .insn_i       (insn_i),
    .rs1_i        (rs1_i),
    .vl_i         (vl_i),
    .sew_i        (sew_i),
    .busy_o       (busy_o),
    .illegal_o    (illegal_o),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_wbe_i   (host_wbe_i),
    .host_raddr_i (host_raddr_i),
    .host_rdata_o (host_rdata_o)
  );

  // Cycle count since the last accepted request and its expected busy length
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_acc   <= 1;
      cur_len     <= 0;
      cur_illegal <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      since_acc   <= 1;
      cur_len     <= req_len;
      cur_illegal <= req_illegal;
    end else begin
      since_acc <= since_acc + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "simulation hung");
    end
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    $display("test failed");
    $fatal(1, "mismatch on %s", what);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_readback: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rb_check |-> host_rdata_o == rb_exp)
    else report_mismatch("readback", $sampled(rb_exp), $sampled(host_rdata_o));

  // Busy for exactly 2G cycles after acceptance
  a_busy_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o == (since_acc <= cur_len))
    else report_mismatch("busy_o", 64'($sampled(since_acc) <= $sampled(cur_len)),
                         64'($sampled(busy_o)));

  a_ready_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> req_ready_o == (since_acc == cur_len))
    else report_mismatch("req_ready_o", 64'($sampled(since_acc) == $sampled(cur_len)),
                         64'($sampled(req_ready_o)));

  a_illegal_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_o == (since_acc == 1 && cur_illegal))
    else report_mismatch("illegal_o", 64'($sampled(since_acc) == 1 && $sampled(cur_illegal)),
                         64'($sampled(illegal_o)));

  // Read phase on odd cycles of a group, write phase on even ones
  a_group_phase: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> DUT.i_sequencer.state_q ==
               ((since_acc % 2 == 1) ? vfu_pkg::S_READ : vfu_pkg::S_WRITE))
    else report_mismatch("sequencer state", 64'(($sampled(since_acc) % 2 == 1) ?
                         vfu_pkg::S_READ : vfu_pkg::S_WRITE),
                         64'($sampled(DUT.i_sequencer.state_q)));

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] ref_elem(input logic [5:0] f6, input logic [31:0] a,
                                           input logic [31:0] b, input logic [31:0] d,
                                           input int ew);
    logic [31:0] mask, sign, r;
    logic        lt;
    mask = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
    sign = 32'd1 << (ew - 1);
    // Offset binary makes the signed compare an unsigned one
    lt = ((a & mask) ^ sign) < ((b & mask) ^ sign);
    case (f6)
      vfu_pkg::F6_VADD: r = a + b;
      vfu_pkg::F6_VSUB: r = a - b;
      vfu_pkg::F6_VMIN: r = lt ? a : b;
      vfu_pkg::F6_VMAX: r = lt ? b : a;
      vfu_pkg::F6_VAND: r = a & b;
      vfu_pkg::F6_VOR:  r = a | b;
      vfu_pkg::F6_VXOR: r = a ^ b;
      vfu_pkg::F6_VMUL: r = a * b;
      default:          r = d + a * b;
    endcase
    return r & mask;
  endfunction

  task automatic apply_model(input logic [5:0] f6, input logic vx, input int vs1,
                             input int vs2, input int vd, input logic [31:0] rs1,
                             input int vl, input int ew);
    int          word, pos;
    logic [63:0] emask;
    logic [31:0] a, b, d;
    emask = (ew == 32) ? 64'hffff_ffff : ((64'd1 << ew) - 64'd1);
    for (int e = 0; e < vl; e++) begin
      word = e * ew / 64;
      pos  = e * ew % 64;
      a = 32'(model_mem[vs2 * VELE + word] >> pos);
      b = vx ? rs1 : 32'(model_mem[vs1 * VELE + word] >> pos);
      d = 32'(model_mem[vd * VELE + word] >> pos);
      model_mem[vd * VELE + word] = (model_mem[vd * VELE + word] & ~(emask << pos))
                                    | (64'(ref_elem(f6, a, b, d, ew)) << pos);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] make_insn(input logic [5:0] f6, input logic [2:0] f3,
                                            input int vs1, input int vs2, input int vd);
    return {f6, 1'b1, 5'(vs2), 5'(vs1), f3, 5'(vd), vfu_pkg::OPV_OPCODE};
  endfunction

  task automatic load_reg(input int idx);
    for (int w = 0; w < VELE; w++) begin
      host_we_i    = 1'b1;
      host_addr_i  = 7'(idx * VELE + w);
      host_wdata_i = {$urandom, $urandom};
      model_mem[idx * VELE + w] = host_wdata_i;
      @(posedge clk_i);
      #1;
    end
    host_we_i = 1'b0;
  endtask

  // Holding keeps req_valid_i high so that the next request waits behind this one
  task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input int vl,
                       input int ew, input logic bad, input logic hold);
    insn_i = insn;
    rs1_i  = rs1;
    vl_i   = 8'(vl);
    case (ew)
      8:       sew_i = vfu_pkg::EW_8;
      16:      sew_i = vfu_pkg::EW_16;
      default: sew_i = vfu_pkg::EW_32;
    endcase
    req_len     = (bad || vl == 0) ? 0 : 2 * ((vl * ew + 63) / 64);
    req_illegal = bad;
    req_valid_i = 1'b1;
    do @(posedge clk_i); while (!req_ready_o);
    #1;
    if (!hold) begin
      req_valid_i = 1'b0;
    end
  endtask

  task automatic wait_idle();
    do @(posedge clk_i); while (busy_o);
    #1;
  endtask

  task automatic check_regs();
    for (int addr = 0; addr < NR_WORDS; addr++) begin
      host_raddr_i = 7'(addr);
      rb_exp       = model_mem[addr];
      rb_check     = 1'b1;
      @(posedge clk_i);
      #1;
    end
    rb_check = 1'b0;
  endtask

  task automatic run_op(input int k, input logic vx, input int ew, input int vl);
    int          vs1, vs2, vd;
    logic [31:0] rs1;
    logic [2:0]  f3;
    vs1 = int'($urandom % 32);
    vs2 = int'($urandom % 32);
    vd  = int'($urandom % 32);
    rs1 = $urandom;
    if (k < 7) begin
      f3 = vx ? vfu_pkg::F3_OPIVX : vfu_pkg::F3_OPIVV;
    end else begin
      f3 = vx ? vfu_pkg::F3_OPMVX : vfu_pkg::F3_OPMVV;
    end
    test_name = $sformatf("%s.%s e%0d vl%0d", op_names[k], vx ? "vx" : "vv", ew, vl);
    load_reg(vs1);
    load_reg(vs2);
    load_reg(vd);
    issue(make_insn(op_codes[k], f3, vs1, vs2, vd), rs1, vl, ew, 1'b0, 1'b0);
    wait_idle();
    apply_model(op_codes[k], vx, vs1, vs2, vd, rs1, vl, ew);
    check_regs();
  endtask

  // Accepted requests that must leave every register untouched
  task automatic run_no_effect(input string name, input logic [31:0] insn, input int vl,
                               input logic bad);
    test_name = name;
    issue(insn, $urandom, vl, 32, bad, 1'b0);
    wait_idle();
    check_regs();
  endtask

  initial begin
    void'($urandom(32'h41ee));
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    insn_i       = '0;
    rs1_i        = '0;
    vl_i         = '0;
    sew_i        = vfu_pkg::EW_32;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_wbe_i   = '1;
    host_raddr_i = '0;
    rb_check     = 1'b0;
    rb_exp       = '0;
    req_len      = 0;
    req_illegal  = 1'b0;
    test_name    = "reset";
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int r = 0; r < vfu_pkg::NR_VREG; r++) begin
      load_reg(r);
    end

    // Full length, vector-vector then vector-scalar, at every width
    for (int ew = 8; ew <= 32; ew = ew * 2) begin
      for (int k = 0; k < 9; k++) begin
        run_op(k, 1'b0, ew, 256 / ew);
      end
      for (int k = 0; k < 8; k++) begin
        run_op(k, 1'b1, ew, 256 / ew);
      end
    end

    // Tail bytes and trailing words
    run_op(0, 1'b0, 8, 13);
    run_op(8, 1'b0, 16, 5);
    run_op(1, 1'b0, 32, 3);
    run_op(3, 1'b0, 8, 1);
    run_op(2, 1'b1, 16, 11);

    // Second request held behind the first, reading the first result
    test_name = "back-to-back";
    load_reg(1);
    load_reg(2);
    load_reg(4);
    load_reg(5);
    issue(make_insn(vfu_pkg::F6_VADD, vfu_pkg::F3_OPIVV, 1, 2, 3), 32'h0, 32, 8, 1'b0, 1'b1);
    issue(make_insn(vfu_pkg::F6_VMACC, vfu_pkg::F3_OPMVV, 3, 4, 5), 32'h0, 14, 16, 1'b0, 1'b0);
    wait_idle();
    apply_model(vfu_pkg::F6_VADD, 1'b0, 1, 2, 3, 32'h0, 32, 8);
    apply_model(vfu_pkg::F6_VMACC, 1'b0, 3, 4, 5, 32'h0, 14, 16);
    check_regs();

    run_no_effect("bad opcode", {vfu_pkg::F6_VADD, 1'b1, 5'd1, 5'd2, vfu_pkg::F3_OPIVV,
                                 5'd3, 7'b0110011}, 8, 1'b1);
    run_no_effect("bad funct6", make_insn(6'b111111, vfu_pkg::F3_OPIVV, 1, 2, 3), 8, 1'b1);
    run_no_effect("vmacc.vx", make_insn(vfu_pkg::F6_VMACC, vfu_pkg::F3_OPMVX, 1, 2, 3),
                  8, 1'b1);
    run_no_effect("vl zero", make_insn(vfu_pkg::F6_VADD, vfu_pkg::F3_OPIVV, 1, 2, 3),
                  0, 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// Free running testbench clock, 4 ns period, starts low
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 2
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* rtl/vfu_top.sv */
// Vector unit top, N_IPU lanes of 32 bits, word width N_IPU*32
// The host port must stay quiet while busy_o is high
`timescale 1ns/10ps
`default_nettype none

module vfu_top #(
  parameter  int unsigned N_IPU  = 2,
  parameter  int unsigned VELE   = 4,
  localparam int unsigned WORD_W = N_IPU * vfu_pkg::ELEN,
  localparam int unsigned NB     = N_IPU * vfu_pkg::ELENB,
  localparam int unsigned ADDR_W = vfu_pkg::VREG_IDX_W + $clog2(VELE)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [31:0]       insn_i,
  input  logic [31:0]       rs1_i,
  input  logic [7:0]        vl_i,
  input  vfu_pkg::vsew_e    sew_i,
  output logic              busy_o,
  output logic              illegal_o,
  input  logic              host_we_i,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic [WORD_W-1:0] host_wdata_i,
  input  logic [NB-1:0]     host_wbe_i,
  input  logic [ADDR_W-1:0] host_raddr_i,
  output logic [WORD_W-1:0] host_rdata_o
);

  vfu_pkg::vfu_op_e               dec_op;
  logic                           dec_use_vs1, dec_use_vs2, dec_vd_is_src, dec_illegal;
  logic [vfu_pkg::VREG_IDX_W-1:0] dec_vs1, dec_vs2, dec_vd;

  logic [2:0][ADDR_W-1:0] vrf_raddr;
  logic [2:0]             vrf_re, vrf_rvalid;
  logic [2:0][WORD_W-1:0] vrf_rdata;
  logic                   vrf_we, vrf_wvalid;
  logic [ADDR_W-1:0]      vrf_waddr;
  logic [NB-1:0]          vrf_wbe;
  logic [WORD_W-1:0]      vrf_wdata;

  vfu_pkg::vfu_op_e  lane_op;
  vfu_pkg::vsew_e    lane_sew;
  logic [WORD_W-1:0] lane_s1, lane_s2, lane_d;

  vfu_decoder i_decoder (
    .insn_i      (insn_i),
    .op_o        (dec_op),
    .use_vs1_o   (dec_use_vs1),
    .use_vs2_o   (dec_use_vs2),
    .vd_is_src_o (dec_vd_is_src),
    .vs1_o       (dec_vs1),
    .vs2_o       (dec_vs2),
    .vd_o        (dec_vd),
    .illegal_o   (dec_illegal)
  );

  vfu_sequencer #(.N_IPU(N_IPU), .VELE(VELE)) i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .op_i         (dec_op),
    .use_vs1_i    (dec_use_vs1),
    .use_vs2_i    (dec_use_vs2),
    .vd_is_src_i  (dec_vd_is_src),
    .illegal_i    (dec_illegal),
    .vs1_i        (dec_vs1),
    .vs2_i        (dec_vs2),
    .vd_i         (dec_vd),
    .rs1_i        (rs1_i),
    .vl_i         (vl_i),
    .sew_i        (sew_i),
    .busy_o       (busy_o),
    .illegal_o    (illegal_o),
    .vrf_raddr_o  (vrf_raddr),
    .vrf_re_o     (vrf_re),
    .vrf_rdata_i  (vrf_rdata),
    .vrf_rvalid_i (vrf_rvalid),
    .vrf_we_o     (vrf_we),
    .vrf_waddr_o  (vrf_waddr),
    .vrf_wbe_o    (vrf_wbe),
    .vrf_wvalid_i (vrf_wvalid),
    .lane_op_o    (lane_op),
    .lane_sew_o   (lane_sew),
    .lane_op_s1_o (lane_s1),
    .lane_op_s2_o (lane_s2),
    .lane_op_d_o  (lane_d)
  );

  for (genvar i = 0; i < N_IPU; i++) begin : gen_ipus
    vfu_ipu i_ipu (
      .op_i     (lane_op),
      .sew_i    (lane_sew),
      .op_s1_i  (lane_s1[i*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .op_s2_i  (lane_s2[i*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .op_d_i   (lane_d[i*vfu_pkg::ELEN +: vfu_pkg::ELEN]),
      .result_o (vrf_wdata[i*vfu_pkg::ELEN +: vfu_pkg::ELEN])
    );
  end

  vfu_vrf #(.N_IPU(N_IPU), .VELE(VELE)) i_vrf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .raddr_i      (vrf_raddr),
    .re_i         (vrf_re),
    .rdata_o      (vrf_rdata),
    .rvalid_o     (vrf_rvalid),
    .we_i         (vrf_we),
    .waddr_i      (vrf_waddr),
    .wbe_i        (vrf_wbe),
    .wdata_i      (vrf_wdata),
    .wvalid_o     (vrf_wvalid),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_wbe_i   (host_wbe_i),
    .host_raddr_i (host_raddr_i),
    .host_rdata_o (host_rdata_o)
  );

endmodule

`default_nettype wire

/* rtl/vfu_vrf.sv */
// Vector register file, VELE words per register, VELE a power of two
// Execution write wins a byte that the host also writes
// Host readback is combinational and only meaningful while the unit is idle
`timescale 1ns/10ps
`default_nettype none

module vfu_vrf #(
  parameter  int unsigned N_IPU  = 2,
  parameter  int unsigned VELE   = 4,
  localparam int unsigned WORD_W = N_IPU * vfu_pkg::ELEN,
  localparam int unsigned NB     = N_IPU * vfu_pkg::ELENB,
  localparam int unsigned ADDR_W = vfu_pkg::VREG_IDX_W + $clog2(VELE)
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [2:0][ADDR_W-1:0] raddr_i,
  input  logic [2:0]             re_i,
  output logic [2:0][WORD_W-1:0] rdata_o,
  output logic [2:0]             rvalid_o,
  input  logic                   we_i,
  input  logic [ADDR_W-1:0]      waddr_i,
  input  logic [NB-1:0]          wbe_i,
  input  logic [WORD_W-1:0]      wdata_i,
  output logic                   wvalid_o,
  input  logic                   host_we_i,
  input  logic [ADDR_W-1:0]      host_addr_i,
  input  logic [WORD_W-1:0]      host_wdata_i,
  input  logic [NB-1:0]          host_wbe_i,
  input  logic [ADDR_W-1:0]      host_raddr_i,
  output logic [WORD_W-1:0]      host_rdata_o
);

  logic [WORD_W-1:0]      mem_q [vfu_pkg::NR_VREG*VELE];
  logic [2:0][WORD_W-1:0] rdata_q;
  logic [2:0][ADDR_W-1:0] raddr_q;
  logic [2:0]             re_q;

  // Byte-enabled writes from both writers
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < NB; b++) begin
      if (we_i && wbe_i[b]) begin
        mem_q[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end else if (host_we_i && host_wbe_i[b]) begin
        mem_q[host_addr_i][b*8 +: 8] <= host_wdata_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < 3; p++) begin
      if (re_i[p]) begin
        rdata_q[p] <= mem_q[raddr_i[p]];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      re_q    <= 3'b000;
      raddr_q <= '0;
    end else begin
      re_q    <= re_i;
      raddr_q <= raddr_i;
    end
  end

  // Data is valid once the request was held for a cycle at one address
  always_comb begin
    for (int p = 0; p < 3; p++) begin
      rvalid_o[p] = re_q[p] && re_i[p] && (raddr_q[p] == raddr_i[p]);
    end
  end

  assign rdata_o      = rdata_q;
  assign wvalid_o     = we_i;
  assign host_rdata_o = mem_q[host_raddr_i];

  a_single_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(host_we_i && we_i));

endmodule

`default_nettype wire

/* rtl/vfu_ipu.sv */
// One combinational lane over a 32-bit word split at the element width
// Results wrap modulo the element width, min and max compare as signed
`timescale 1ns/10ps
`default_nettype none

module vfu_ipu (
  input  vfu_pkg::vfu_op_e op_i,
  input  vfu_pkg::vsew_e   sew_i,
  input  logic [31:0]      op_s1_i,
  input  logic [31:0]      op_s2_i,
  input  logic [31:0]      op_d_i,
  output logic [31:0]      result_o
);

  // Operands arrive sign extended, the caller keeps the low bits
  function automatic logic [31:0] elem_alu(input vfu_pkg::vfu_op_e op,
                                           input logic signed [31:0] s2,
                                           input logic signed [31:0] s1,
                                           input logic signed [31:0] d);
    logic signed [31:0] prod;
    prod = s2 * s1;
    case (op)
      vfu_pkg::OP_ADD:  elem_alu = s2 + s1;
      vfu_pkg::OP_SUB:  elem_alu = s2 - s1;
      vfu_pkg::OP_MIN:  elem_alu = (s2 < s1) ? s2 : s1;
      vfu_pkg::OP_MAX:  elem_alu = (s2 > s1) ? s2 : s1;
      vfu_pkg::OP_AND:  elem_alu = s2 & s1;
      vfu_pkg::OP_OR:   elem_alu = s2 | s1;
      vfu_pkg::OP_XOR:  elem_alu = s2 ^ s1;
      vfu_pkg::OP_MUL:  elem_alu = prod;
      vfu_pkg::OP_MACC: elem_alu = d + prod;
      default:          elem_alu = '0;
    endcase
  endfunction

  logic [31:0] res_8, res_16, res_32;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      res_8[i*8 +: 8] = 8'(elem_alu(op_i,
                                    32'(signed'(op_s2_i[i*8 +: 8])),
                                    32'(signed'(op_s1_i[i*8 +: 8])),
                                    32'(signed'(op_d_i[i*8 +: 8]))));
    end
    for (int i = 0; i < 2; i++) begin
      res_16[i*16 +: 16] = 16'(elem_alu(op_i,
                                        32'(signed'(op_s2_i[i*16 +: 16])),
                                        32'(signed'(op_s1_i[i*16 +: 16])),
                                        32'(signed'(op_d_i[i*16 +: 16]))));
    end
    res_32 = elem_alu(op_i, signed'(op_s2_i), signed'(op_s1_i), signed'(op_d_i));
  end

  always_comb begin
    case (sew_i)
      vfu_pkg::EW_8:  result_o = res_8;
      vfu_pkg::EW_16: result_o = res_16;
      default:        result_o = res_32;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/vfu_sequencer.sv */
// Walks vd one register-file word per two cycles, read then write
// vl must not exceed VELE words worth of elements at the chosen width
// A new request is taken while idle or during the last write
`timescale 1ns/10ps
`default_nettype none

module vfu_sequencer #(
  parameter  int unsigned N_IPU  = 2,
  parameter  int unsigned VELE   = 4,
  localparam int unsigned WORD_W = N_IPU * vfu_pkg::ELEN,
  localparam int unsigned NB     = N_IPU * vfu_pkg::ELENB,
  localparam int unsigned VELE_W = $clog2(VELE),
  localparam int unsigned ADDR_W = vfu_pkg::VREG_IDX_W + VELE_W
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  vfu_pkg::vfu_op_e               op_i,
  input  logic                           use_vs1_i,
  input  logic                           use_vs2_i,
  input  logic                           vd_is_src_i,
  input  logic                           illegal_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0] vs1_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0] vs2_i,
  input  logic [vfu_pkg::VREG_IDX_W-1:0] vd_i,
  input  logic [31:0]                    rs1_i,
  input  logic [7:0]                     vl_i,
  input  vfu_pkg::vsew_e                 sew_i,
  output logic                           busy_o,
  output logic                           illegal_o,
  output logic [2:0][ADDR_W-1:0]         vrf_raddr_o,
  output logic [2:0]                     vrf_re_o,
  input  logic [2:0][WORD_W-1:0]         vrf_rdata_i,
  input  logic [2:0]                     vrf_rvalid_i,
  output logic                           vrf_we_o,
  output logic [ADDR_W-1:0]              vrf_waddr_o,
  output logic [NB-1:0]                  vrf_wbe_o,
  input  logic                           vrf_wvalid_i,
  output vfu_pkg::vfu_op_e               lane_op_o,
  output vfu_pkg::vsew_e                 lane_sew_o,
  output logic [WORD_W-1:0]              lane_op_s1_o,
  output logic [WORD_W-1:0]              lane_op_s2_o,
  output logic [WORD_W-1:0]              lane_op_d_o
);

  vfu_pkg::seq_state_e     state_q, state_d;
  logic [7:0]              vl_q, vl_d;
  logic [2:0][ADDR_W-1:0]  addr_q, addr_d;
  logic [2:0]              src_mask_q;
  logic                    illegal_q;
  vfu_pkg::vfu_op_e        op_q;
  vfu_pkg::vsew_e          sew_q;
  logic [31:0]             rs1_q;

  logic       accept, start, operands_ready, write_done, last_group;
  logic [7:0] epw;
  logic [9:0] valid_bytes;

  assign accept = req_valid_i && req_ready_o;
  assign start  = accept && !illegal_i && (vl_i != 8'd0);

  // Elements per word and bytes covered by the remaining count
  always_comb begin
    case (sew_q)
      vfu_pkg::EW_8: begin
        epw         = 8'(NB);
        valid_bytes = {2'b00, vl_q};
      end
      vfu_pkg::EW_16: begin
        epw         = 8'(NB / 2);
        valid_bytes = {1'b0, vl_q, 1'b0};
      end
      default: begin
        epw         = 8'(N_IPU);
        valid_bytes = {vl_q, 2'b00};
      end
    endcase
  end

  assign last_group     = (vl_q <= epw);
  assign operands_ready = &(vrf_rvalid_i | ~src_mask_q);
  assign write_done     = vrf_we_o && vrf_wvalid_i;

  assign busy_o      = (state_q != vfu_pkg::S_IDLE);
  assign req_ready_o = (state_q == vfu_pkg::S_IDLE) || (last_group && write_done);
  assign illegal_o   = illegal_q;

  ////////////////////
  // Group stepping
  ////////////////////

  always_comb begin
    state_d = state_q;
    vl_d    = vl_q;
    addr_d  = addr_q;
    case (state_q)
      vfu_pkg::S_READ: state_d = vfu_pkg::S_WRITE;
      vfu_pkg::S_WRITE: begin
        if (write_done) begin
          if (last_group) begin
            state_d = vfu_pkg::S_IDLE;
            vl_d    = 8'd0;
          end else begin
            state_d = vfu_pkg::S_READ;
            vl_d    = vl_q - epw;
            for (int p = 0; p < 3; p++) begin
              addr_d[p] = addr_q[p] + ADDR_W'(1);
            end
          end
        end
      end
      default: state_d = vfu_pkg::S_IDLE;
    endcase
    if (start) begin
      state_d   = vfu_pkg::S_READ;
      vl_d      = vl_i;
      addr_d[0] = {vs2_i, VELE_W'(0)};
      addr_d[1] = {vs1_i, VELE_W'(0)};
      addr_d[2] = {vd_i, VELE_W'(0)};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= vfu_pkg::S_IDLE;
      vl_q       <= 8'd0;
      addr_q     <= '0;
      src_mask_q <= 3'b000;
      illegal_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      vl_q      <= vl_d;
      addr_q    <= addr_d;
      illegal_q <= accept && illegal_i;
      if (start) begin
        src_mask_q <= {vd_is_src_i, use_vs1_i, use_vs2_i};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q  <= op_i;
      sew_q <= sew_i;
      rs1_q <= rs1_i;
    end
  end

  ////////////////////
  // Register file side
  ////////////////////

  // Reads stay asserted through S_WRITE so rvalid comes back there
  assign vrf_raddr_o = addr_q;
  assign vrf_re_o    = busy_o ? src_mask_q : 3'b000;
  assign vrf_we_o    = (state_q == vfu_pkg::S_WRITE) && operands_ready;
  assign vrf_waddr_o = addr_q[2];
  assign vrf_wbe_o   = last_group ? ({NB{1'b1}} >> (10'(NB) - valid_bytes)) : {NB{1'b1}};

  assign lane_op_o    = op_q;
  assign lane_sew_o   = sew_q;
  assign lane_op_s2_o = vrf_rdata_i[0];
  assign lane_op_d_o  = vrf_rdata_i[2];

  // Scalar operand splatted across every element of the word
  always_comb begin
    if (src_mask_q[1]) begin
      lane_op_s1_o = vrf_rdata_i[1];
    end else if (sew_q == vfu_pkg::EW_8) begin
      lane_op_s1_o = {(WORD_W / 8){rs1_q[7:0]}};
    end else if (sew_q == vfu_pkg::EW_16) begin
      lane_op_s1_o = {(WORD_W / 16){rs1_q[15:0]}};
    end else begin
      lane_op_s1_o = {N_IPU{rs1_q}};
    end
  end

  // Operands must be back in time for the fixed two-cycle group
  a_write_on_time: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == vfu_pkg::S_WRITE |-> vrf_we_o);

  // Every write covers at least one element
  a_wbe_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    vrf_we_o |-> vrf_wbe_o != '0);

endmodule

`default_nettype wire

/* rtl/vfu_decoder.sv */
// Combinational OP-V decoder, the vm bit is ignored since masking is absent
// Scalar forms take rs1 from the request, not from a register
`timescale 1ns/10ps
`default_nettype none

module vfu_decoder (
  input  logic [31:0]                       insn_i,
  output vfu_pkg::vfu_op_e                  op_o,
  output logic                              use_vs1_o,
  output logic                              use_vs2_o,
  output logic                              vd_is_src_o,
  output logic [vfu_pkg::VREG_IDX_W-1:0]    vs1_o,
  output logic [vfu_pkg::VREG_IDX_W-1:0]    vs2_o,
  output logic [vfu_pkg::VREG_IDX_W-1:0]    vd_o,
  output logic                              illegal_o
);

  logic [5:0] funct6;
  logic [2:0] funct3;
  logic       is_vx;

  assign funct6 = insn_i[31:26];
  assign funct3 = insn_i[14:12];
  assign is_vx  = (funct3 == vfu_pkg::F3_OPIVX) || (funct3 == vfu_pkg::F3_OPMVX);

  assign vs2_o = insn_i[24:20];
  assign vs1_o = insn_i[19:15];
  assign vd_o  = insn_i[11:7];

  always_comb begin
    op_o        = vfu_pkg::OP_ADD;
    use_vs1_o   = !is_vx;
    use_vs2_o   = 1'b1;
    vd_is_src_o = 1'b0;
    illegal_o   = 1'b0;

    case (funct3)
      vfu_pkg::F3_OPIVV, vfu_pkg::F3_OPIVX: begin
        case (funct6)
          vfu_pkg::F6_VADD: op_o = vfu_pkg::OP_ADD;
          vfu_pkg::F6_VSUB: op_o = vfu_pkg::OP_SUB;
          vfu_pkg::F6_VMIN: op_o = vfu_pkg::OP_MIN;
          vfu_pkg::F6_VMAX: op_o = vfu_pkg::OP_MAX;
          vfu_pkg::F6_VAND: op_o = vfu_pkg::OP_AND;
          vfu_pkg::F6_VOR:  op_o = vfu_pkg::OP_OR;
          vfu_pkg::F6_VXOR: op_o = vfu_pkg::OP_XOR;
          default:          illegal_o = 1'b1;
        endcase
      end
      vfu_pkg::F3_OPMVV, vfu_pkg::F3_OPMVX: begin
        case (funct6)
          vfu_pkg::F6_VMUL: op_o = vfu_pkg::OP_MUL;
          vfu_pkg::F6_VMACC: begin
            op_o        = vfu_pkg::OP_MACC;
            vd_is_src_o = 1'b1;
            // Only the vector-vector accumulate is supported
            if (is_vx) begin
              illegal_o = 1'b1;
            end
          end
          default: illegal_o = 1'b1;
        endcase
      end
      default: illegal_o = 1'b1;
    endcase

    if (insn_i[6:0] != vfu_pkg::OPV_OPCODE) begin
      illegal_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/vfu_pkg.sv */
// Shared widths, enums and OP-V field codes of the vector unit
// Element width and opcode encodings are internal, not the RVV vtype bits
`default_nettype none

package vfu_pkg;

  // Lane word and register file geometry
  localparam int unsigned ELEN       = 32;
  localparam int unsigned ELENB      = ELEN / 8;
  localparam int unsigned NR_VREG    = 32;
  localparam int unsigned VREG_IDX_W = $clog2(NR_VREG);

  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vsew_e;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_MIN,
    OP_MAX,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL,
    OP_MACC
  } vfu_op_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE
  } seq_state_e;

  ////////////////////
  // OP-V encoding
  ////////////////////

  localparam logic [6:0] OPV_OPCODE = 7'b1010111;

  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;

  // Integer group
  localparam logic [5:0] F6_VADD  = 6'b000000;
  localparam logic [5:0] F6_VSUB  = 6'b000010;
  localparam logic [5:0] F6_VMIN  = 6'b000101;
  localparam logic [5:0] F6_VMAX  = 6'b000111;
  localparam logic [5:0] F6_VAND  = 6'b001001;
  localparam logic [5:0] F6_VOR   = 6'b001010;
  localparam logic [5:0] F6_VXOR  = 6'b001011;
  // Multiply group
  localparam logic [5:0] F6_VMUL  = 6'b100101;
  localparam logic [5:0] F6_VMACC = 6'b101101;

endpackage

`default_nettype wire
